// File: source/lc3Pkg.sv
`default_nettype none

package lc3Pkg;

    typedef logic [15:0] word_t;    // Data or address word
    typedef logic [2:0]  regIdx_t;  // General register index

    // Standard LC-3 encodings, dropped codes kept for decode
    typedef enum logic [3:0] {
        opBr   = 4'h0,
        opAdd  = 4'h1,
        opLd   = 4'h2,
        opSt   = 4'h3,
        opJsr  = 4'h4,
        opAnd  = 4'h5,
        opLdr  = 4'h6,
        opStr  = 4'h7,
        opRti  = 4'h8,  // Dropped, halts
        opNot  = 4'h9,
        opLdi  = 4'hA,  // Dropped, halts
        opSti  = 4'hB,  // Dropped, halts
        opJmp  = 4'hC,  // Also RET
        opRes  = 4'hD,  // Reserved, halts
        opLea  = 4'hE,
        opTrap = 4'hF
    } opcode_t;

    typedef enum logic [2:0] {
        fetchAddr, fetchRead, fetchLoad, fetchIr, execute, jsrLink, halt
    } state_t;

    typedef enum logic [1:0] {busAlu, busAddr, busMdr, busPc} busSrc_t;
    typedef enum logic [1:0] {pcInc, pcSum, pcBus} pcSel_t;
    typedef enum logic [1:0] {off11, off9, off6, offZero} addr2Sel_t;
    typedef enum logic [1:0] {aluAdd, aluAnd, aluNot, aluPassA} aluOp_t;

    typedef struct packed {
        logic      ldReg;
        logic      ldCc;
        logic      ldPc;
        logic      ldMar;
        logic      ldMdr;
        busSrc_t   busSel;
        pcSel_t    pcSel;
        logic      addr1Base;   // 0 PC, 1 srcA
        addr2Sel_t addr2Sel;
        logic      vectSel;     // Trap vector instead of sum
        aluOp_t    aluOp;
        logic      useImm;
        regIdx_t   sr1;
        regIdx_t   sr2;
        regIdx_t   dr;
        logic      memEn;
        logic      writeEn;
    } ctrl_t;

    typedef struct packed {
        logic  en;
        logic  we;
        word_t addr;
        word_t wrData;
    } memReq_t;

    typedef struct packed {
        logic n;
        logic z;
        logic p;
    } nzp_t;

endpackage

`default_nettype wire

// File: source/lc3Control.sv
`timescale 1ns/1ns
`default_nettype none

module lc3Control (
    input  wire               clk,
    input  wire               rst_n,
    input  wire lc3Pkg::word_t bus,
    input  wire lc3Pkg::nzp_t  flags,
    output lc3Pkg::ctrl_t     ctrl,
    output lc3Pkg::word_t     ir,
    output logic              halted
);

    import lc3Pkg::*;

    state_t   state;
    state_t   nextState;
    logic [2:0] stepCnt;        // Execute step within instruction
    logic     stepDone;         // Last execute step of instruction
    opcode_t  opcode;
    logic [2:0] condHit;

    assign opcode  = opcode_t'(ir[15:12]);
    assign condHit = {flags.n, flags.z, flags.p} & ir[11:9];  // BR mask vs flags
    assign halted  = (state == halt);

    ////////////////////////////////////////////////////////////
    // Sequencer registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fetchAddr;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (state == fetchIr) begin
            ir <= bus;                          // MDR is on the bus here
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stepCnt <= '0;
        end else if (state == execute && !stepDone) begin
            stepCnt <= stepCnt + 3'd1;
        end else begin
            stepCnt <= '0;                      // Fresh count per instruction
        end
    end

    ////////////////////////////////////////////////////////////
    // Control word decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        ctrl      = '0;                         // All strobes low by default
        nextState = state;
        stepDone  = 1'b0;
        case (state)
            fetchAddr: begin
                ctrl.busSel = busPc;            // MAR <- PC
                ctrl.ldMar  = 1'b1;
                nextState   = fetchRead;
            end
            fetchRead: begin
                ctrl.memEn = 1'b1;              // Read at MAR
                ctrl.ldPc  = 1'b1;
                ctrl.pcSel = pcInc;
                nextState  = fetchLoad;
            end
            fetchLoad: begin
                ctrl.ldMdr = 1'b1;              // MDR <- ramData
                nextState  = fetchIr;
            end
            fetchIr: begin
                ctrl.busSel = busMdr;
                nextState   = execute;
            end
            execute: begin
                stepDone  = 1'b1;               // Single-step unless overridden
                nextState = fetchAddr;
                case (opcode)
                    opBr: begin
                        ctrl.pcSel    = pcSum;  // PC + off9
                        ctrl.addr2Sel = off9;
                        ctrl.ldPc     = |condHit;
                    end
                    opAdd, opAnd: begin
                        ctrl.sr1    = ir[8:6];
                        ctrl.sr2    = ir[2:0];
                        ctrl.dr     = ir[11:9];
                        ctrl.useImm = ir[5];
                        ctrl.aluOp  = (opcode == opAdd) ? aluAdd : aluAnd;
                        ctrl.busSel = busAlu;
                        ctrl.ldReg  = 1'b1;
                        ctrl.ldCc   = 1'b1;
                    end
                    opNot: begin
                        ctrl.sr1    = ir[8:6];
                        ctrl.dr     = ir[11:9];
                        ctrl.aluOp  = aluNot;
                        ctrl.busSel = busAlu;
                        ctrl.ldReg  = 1'b1;
                        ctrl.ldCc   = 1'b1;
                    end
                    opLea: begin
                        ctrl.dr       = ir[11:9];
                        ctrl.addr2Sel = off9;
                        ctrl.busSel   = busAddr;
                        ctrl.ldReg    = 1'b1;
                        ctrl.ldCc     = 1'b1;
                    end
                    opJmp: begin
                        ctrl.sr1    = ir[8:6];  // R7 for RET
                        ctrl.aluOp  = aluPassA;
                        ctrl.busSel = busAlu;
                        ctrl.pcSel  = pcBus;
                        ctrl.ldPc   = 1'b1;
                    end
                    opJsr: begin
                        ctrl.dr     = 3'd7;     // Link first
                        ctrl.busSel = busPc;
                        ctrl.ldReg  = 1'b1;
                        nextState   = jsrLink;
                    end
                    opLd, opLdr: begin
                        stepDone  = (stepCnt == 3'd3);
                        nextState = stepDone ? fetchAddr : execute;
                        ctrl.sr1  = ir[8:6];    // Base for LDR
                        ctrl.dr   = ir[11:9];
                        case (stepCnt)
                            3'd0: begin
                                ctrl.addr1Base = (opcode == opLdr);
                                ctrl.addr2Sel  = (opcode == opLdr) ? off6 : off9;
                                ctrl.busSel    = busAddr;
                                ctrl.ldMar     = 1'b1;
                            end
                            3'd1: ctrl.memEn = 1'b1;
                            3'd2: ctrl.ldMdr = 1'b1;
                            default: begin
                                ctrl.busSel = busMdr;
                                ctrl.ldReg  = 1'b1;
                                ctrl.ldCc   = 1'b1;
                            end
                        endcase
                    end
                    opSt, opStr: begin
                        stepDone  = (stepCnt == 3'd2);
                        nextState = stepDone ? fetchAddr : execute;
                        case (stepCnt)
                            3'd0: begin
                                ctrl.sr1       = ir[8:6];
                                ctrl.addr1Base = (opcode == opStr);
                                ctrl.addr2Sel  = (opcode == opStr) ? off6 : off9;
                                ctrl.busSel    = busAddr;
                                ctrl.ldMar     = 1'b1;
                            end
                            3'd1: begin
                                ctrl.sr1    = ir[11:9]; // Source register
                                ctrl.aluOp  = aluPassA;
                                ctrl.busSel = busAlu;
                                ctrl.ldMdr  = 1'b1;
                            end
                            default: begin
                                ctrl.memEn   = 1'b1;
                                ctrl.writeEn = 1'b1;
                            end
                        endcase
                    end
                    opTrap: begin
                        stepDone  = (stepCnt == 3'd4);
                        nextState = stepDone ? fetchAddr : execute;
                        case (stepCnt)
                            3'd0: begin
                                ctrl.dr     = 3'd7; // R7 <- PC
                                ctrl.busSel = busPc;
                                ctrl.ldReg  = 1'b1;
                            end
                            3'd1: begin
                                ctrl.vectSel = 1'b1;
                                ctrl.busSel  = busAddr;
                                ctrl.ldMar   = 1'b1;
                            end
                            3'd2: ctrl.memEn = 1'b1;
                            3'd3: ctrl.ldMdr = 1'b1;
                            default: begin
                                ctrl.busSel = busMdr;   // Routine address
                                ctrl.pcSel  = pcBus;
                                ctrl.ldPc   = 1'b1;
                            end
                        endcase
                    end
                    default: nextState = halt;  // Reserved and dropped codes
                endcase
            end
            jsrLink: begin
                ctrl.pcSel = pcSum;
                ctrl.ldPc  = 1'b1;
                if (ir[11]) begin
                    ctrl.addr2Sel = off11;      // JSR, PC + off11
                end else begin
                    ctrl.sr1       = ir[8:6];   // JSRR, base + 0
                    ctrl.addr1Base = 1'b1;
                    ctrl.addr2Sel  = offZero;
                end
                nextState = fetchAddr;
            end
            default: nextState = halt;          // Stay until reset
        endcase
    end

endmodule

`default_nettype wire

// File: source/lc3AddrUnit.sv
`timescale 1ns/1ns
`default_nettype none

module lc3AddrUnit #(
    parameter lc3Pkg::word_t resetPc = 16'h3000
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire lc3Pkg::ctrl_t ctrl,
    input  wire lc3Pkg::word_t ir,
    input  wire lc3Pkg::word_t srcA,
    input  wire lc3Pkg::word_t bus,
    output lc3Pkg::word_t     pc,
    output lc3Pkg::word_t     addrResult
);

    import lc3Pkg::*;

    word_t base;
    word_t offset;
    word_t addrSum;

    assign base = ctrl.addr1Base ? srcA : pc;

    always_comb begin
        case (ctrl.addr2Sel)
            off11:   offset = {{5{ir[10]}}, ir[10:0]};
            off9:    offset = {{7{ir[8]}}, ir[8:0]};
            off6:    offset = {{10{ir[5]}}, ir[5:0]};
            default: offset = '0;               // JSRR target
        endcase
    end

    assign addrSum    = base + offset;
    assign addrResult = ctrl.vectSel ? {8'h00, ir[7:0]} : addrSum;  // Trap vector zext

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= resetPc;
        end else if (ctrl.ldPc) begin
            case (ctrl.pcSel)
                pcInc:   pc <= pc + 16'd1;
                pcSum:   pc <= addrSum;     // Branch and JSR targets
                default: pc <= bus;         // JMP and TRAP
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/lc3Alu.sv
`timescale 1ns/1ns
`default_nettype none

module lc3Alu (
    input  wire lc3Pkg::ctrl_t ctrl,
    input  wire lc3Pkg::word_t ir,
    input  wire lc3Pkg::word_t srcA,
    input  wire lc3Pkg::word_t srcB,
    output lc3Pkg::word_t     aluResult
);

    import lc3Pkg::*;

    word_t opB;

    // imm5 sign extended for immediate forms
    assign opB = ctrl.useImm ? {{11{ir[4]}}, ir[4:0]} : srcB;

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluResult = srcA + opB;
            aluAnd:  aluResult = srcA & opB;
            aluNot:  aluResult = ~srcA;
            default: aluResult = srcA;      // Stores and JMP
        endcase
    end

endmodule

`default_nettype wire

// File: source/lc3RegFile.sv
`timescale 1ns/1ns
`default_nettype none

module lc3RegFile (
    input  wire               clk,
    input  wire               rst_n,
    input  wire lc3Pkg::ctrl_t ctrl,
    input  wire lc3Pkg::word_t bus,
    output lc3Pkg::word_t     srcA,
    output lc3Pkg::word_t     srcB
);

    import lc3Pkg::*;

    word_t regs [8];                    // R0..R7

    assign srcA = regs[ctrl.sr1];
    assign srcB = regs[ctrl.sr2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.ldReg) begin
            regs[ctrl.dr] <= bus;       // Single write port
        end
    end

endmodule

`default_nettype wire

// File: source/lc3BusUnit.sv
`timescale 1ns/1ns
`default_nettype none

module lc3BusUnit (
    input  wire               clk,
    input  wire               rst_n,
    input  wire lc3Pkg::ctrl_t ctrl,
    input  wire lc3Pkg::word_t aluResult,
    input  wire lc3Pkg::word_t addrResult,
    input  wire lc3Pkg::word_t pc,
    input  wire lc3Pkg::word_t ramData,
    output lc3Pkg::word_t     bus,
    output lc3Pkg::nzp_t      flags,
    output lc3Pkg::memReq_t   memReq
);

    import lc3Pkg::*;

    word_t mar;
    word_t mdr;
    logic  rdPending;                   // Read issued last cycle

    always_comb begin
        case (ctrl.busSel)
            busAlu:  bus = aluResult;
            busAddr: bus = addrResult;
            busMdr:  bus = mdr;
            default: bus = pc;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Memory interface registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ctrl.ldMar) begin
            mar <= bus;
        end
        if (ctrl.ldMdr) begin
            mdr <= rdPending ? ramData : bus;   // Load data or store data
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdPending <= 1'b0;
        end else begin
            rdPending <= ctrl.memEn & ~ctrl.writeEn;
        end
    end

    // Request straight from strobes, RAM registers it
    assign memReq = '{en: ctrl.memEn, we: ctrl.writeEn, addr: mar, wrData: mdr};

    ////////////////////////////////////////////////////////////
    // Condition codes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '{n: 1'b0, z: 1'b1, p: 1'b0};
        end else if (ctrl.ldCc) begin
            flags.n <= bus[15];
            flags.z <= (bus == '0);
            flags.p <= ~bus[15] & (bus != '0);
        end
    end

endmodule

`default_nettype wire

// File: source/lc3Top.sv
`timescale 1ns/1ns
`default_nettype none

module lc3Top #(
    parameter lc3Pkg::word_t resetPc = 16'h3000
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire lc3Pkg::word_t   ramData,
    output lc3Pkg::memReq_t     memReq,
    output logic                halted
);

    import lc3Pkg::*;

    ctrl_t ctrl;
    word_t ir;
    word_t bus;
    nzp_t  flags;
    word_t srcA;
    word_t srcB;
    word_t pc;
    word_t addrResult;
    word_t aluResult;

    lc3Control u_control (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (bus),
        .flags  (flags),
        .ctrl   (ctrl),
        .ir     (ir),
        .halted (halted)
    );

    lc3AddrUnit #(.resetPc(resetPc)) u_addrUnit (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .ir         (ir),
        .srcA       (srcA),
        .bus        (bus),
        .pc         (pc),
        .addrResult (addrResult)
    );

    lc3Alu u_alu (
        .ctrl      (ctrl),
        .ir        (ir),
        .srcA      (srcA),
        .srcB      (srcB),
        .aluResult (aluResult)
    );

    lc3RegFile u_regFile (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl),
        .bus   (bus),
        .srcA  (srcA),
        .srcB  (srcB)
    );

    lc3BusUnit u_busUnit (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .aluResult  (aluResult),
        .addrResult (addrResult),
        .pc         (pc),
        .ramData    (ramData),
        .bus        (bus),
        .flags      (flags),
        .memReq     (memReq)
    );

endmodule

`default_nettype wire

// File: sim/tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
    parameter int periodNs    = 8,
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;                       // In reset from time zero
        forever #(periodNs / 2) clk = ~clk;
    end

    // Reset low for a fixed count of rising edges
    task automatic applyReset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (resetCycles) @(posedge clk);
        rst_n <= 1'b1;
    endtask

endmodule

`default_nettype wire

// File: sim/lc3Tb_assert.sv
`timescale 1ns/1ns
`default_nettype none

module lc3Tb_assert (
    input wire                  clk,
    input wire                  rst_n,
    input wire lc3Pkg::memReq_t memReq,
    input wire                  halted
);

    import lc3Pkg::*;

    int failCount = 0;                  // Failed assertion count

    // Write strobe only with enable
    weImpliesEn: assert property (@(posedge clk) disable iff (!rst_n)
        memReq.we |-> memReq.en)
        else begin
            $error("write strobe without memory enable");
            failCount++;
        end

    // Halt is sticky until reset
    haltSticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else begin
            $error("halted fell without reset");
            failCount++;
        end

    quietWhenHalted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !memReq.en)
        else begin
            $error("memory request while halted");
            failCount++;
        end

endmodule

bind lc3Top lc3Tb_assert u_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .memReq (memReq),
    .halted (halted)
);

`default_nettype wire

// File: sim/lc3Checker.sv
`timescale 1ns/1ns
`default_nettype none

module lc3Checker #(
    parameter lc3Pkg::word_t startPc = 16'h3000,
    parameter int timeoutCycles      = 400
) (
    input wire                  clk,
    input wire lc3Pkg::memReq_t memReq,
    input wire                  halted
);

    import lc3Pkg::*;

    word_t refMem [65536];              // Private image copy
    word_t expAddr [$];
    word_t expData [$];
    int    errors      = 0;
    int    testsRun    = 0;
    int    testsFailed = 0;

    function automatic word_t sext(input word_t x, input int bits);
        logic signed [15:0] t;
        t = x << (16 - bits);
        return t >>> (16 - bits);
    endfunction

    function automatic logic [2:0] ccOf(input word_t v);
        return {v[15], v == 16'h0000, !v[15] && v != 16'h0000};
    endfunction

    function automatic void recordStore(input word_t a, input word_t d);
        expAddr.push_back(a);
        expData.push_back(d);
        refMem[a] = d;                  // Later loads see it
    endfunction

    ////////////////////////////////////////////////////////////
    // ISA reference model
    ////////////////////////////////////////////////////////////

    function automatic void refRun();
        word_t      r [8];
        word_t      pc;
        word_t      ir;
        word_t      v;
        word_t      link;
        logic [2:0] nzp;
        int         steps;
        bit         stop;
        for (int i = 0; i < 8; i++) begin
            r[i] = '0;
        end
        pc    = startPc;
        nzp   = 3'b010;                 // Z after reset
        steps = 0;
        stop  = 1'b0;
        expAddr.delete();
        expData.delete();
        while (!stop && steps < 5000) begin
            ir = refMem[pc];
            pc = pc + 16'd1;
            steps++;
            case (ir[15:12])
                4'h0: if (|(ir[11:9] & nzp)) pc = pc + sext(ir, 9);
                4'h1, 4'h5, 4'h9: begin
                    v = ir[5] ? sext(ir, 5) : r[ir[2:0]];
                    if (ir[15:12] == 4'h1) v = r[ir[8:6]] + v;
                    else if (ir[15:12] == 4'h5) v = r[ir[8:6]] & v;
                    else v = ~r[ir[8:6]];
                    r[ir[11:9]] = v;
                    nzp = ccOf(v);
                end
                4'h2, 4'h6: begin
                    if (ir[15:12] == 4'h2) v = refMem[pc + sext(ir, 9)];
                    else v = refMem[r[ir[8:6]] + sext(ir, 6)];
                    r[ir[11:9]] = v;
                    nzp = ccOf(v);
                end
                4'h3: recordStore(pc + sext(ir, 9), r[ir[11:9]]);
                4'h7: recordStore(r[ir[8:6]] + sext(ir, 6), r[ir[11:9]]);
                4'h4: begin
                    link = pc;
                    pc   = ir[11] ? pc + sext(ir, 11) : r[ir[8:6]];
                    r[7] = link;
                end
                4'hC: pc = r[ir[8:6]];      // JMP and RET
                4'hE: begin
                    v = pc + sext(ir, 9);
                    r[ir[11:9]] = v;
                    nzp = ccOf(v);
                end
                4'hF: begin
                    r[7] = pc;
                    pc   = refMem[{8'h00, ir[7:0]}];
                end
                default: stop = 1'b1;       // Reserved and dropped codes
            endcase
        end
    endfunction

    // Snapshot image before reset release
    task automatic prepare();
        for (int i = 0; i < 65536; i++) begin
            refMem[i] = lc3Tb.ram[i];
        end
        refRun();
    endtask

    ////////////////////////////////////////////////////////////
    // Store watcher
    ////////////////////////////////////////////////////////////

    task automatic runTest(input int num, input string name);
        int idx;
        int idle;
        int errs0;
        bit done;
        idx   = 0;
        idle  = 0;
        errs0 = errors;
        done  = 1'b0;
        while (!done) begin
            @(negedge clk);                 // Mid-cycle, outputs settled
            idle++;
            if (memReq.en && memReq.we) begin
                if (idx >= expAddr.size()) begin
                    $display("Unexpected extra store at %0t to address %h", $time, memReq.addr);
                    errors++;
                end else begin
                    if (memReq.addr !== expAddr[idx]) begin
                        $display("Mismatch at %0t: memReq.addr expected %h got %h",
                                 $time, expAddr[idx], memReq.addr);
                        errors++;
                    end
                    if (memReq.wrData !== expData[idx]) begin
                        $display("Mismatch at %0t: memReq.wrData expected %h got %h",
                                 $time, expData[idx], memReq.wrData);
                        errors++;
                    end
                end
                idx++;
                idle = 0;
            end
            if (halted) begin
                done = 1'b1;
            end else if (idle > timeoutCycles) begin
                $display("Timed out at %0t waiting for a store or for halt", $time);
                errors++;
                done = 1'b1;
            end
        end
        // Short watch window after halt
        for (int c = 0; c < 16 && halted; c++) begin
            @(negedge clk);
            if (memReq.en) begin
                $display("Memory request at %0t after the processor halted", $time);
                errors++;
            end
        end
        if (idx != expAddr.size()) begin
            $display("Mismatch at %0t: store count expected %0d got %0d",
                     $time, expAddr.size(), idx);
            errors++;
        end
        testsRun++;
        if (errors == errs0) begin
            $display("Test %0d %s: ok, %0d stores", num, name, idx);
        end else begin
            testsFailed++;
            $display("Test %0d %s: failed with %0d errors", num, name, errors - errs0);
        end
    endtask

endmodule

`default_nettype wire

// File: sim/lc3Tb.sv
`timescale 1ns/1ns
`default_nettype none

module lc3Tb;

    import lc3Pkg::*;

    logic    clk;
    logic    rst_n;
    word_t   ramData;
    memReq_t memReq;
    logic    halted;
    word_t   ram [65536];
    word_t   lp;                        // Program load pointer
    integer  seed;

    tbClock #(.periodNs(8), .resetCycles(10)) u_clock (.clk(clk), .rst_n(rst_n));

    lc3Top #(.resetPc(16'h3000)) u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .ramData (ramData),
        .memReq  (memReq),
        .halted  (halted)
    );

    lc3Checker #(.startPc(16'h3000)) u_check (.clk(clk), .memReq(memReq), .halted(halted));

    // Synchronous RAM with read data one edge later
    always @(posedge clk) begin
        if (memReq.en) begin
            if (memReq.we) ram[memReq.addr] <= memReq.wrData;
            else ramData <= ram[memReq.addr];
        end
    end

    ////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////

    function automatic word_t f9(input logic [3:0] op, input regIdx_t r, input word_t target);
        word_t d;
        d = target - (lp + 16'd1);      // PC-relative from next word
        return {op, r, d[8:0]};
    endfunction

    function automatic word_t f6(input logic [3:0] op, input regIdx_t r, input regIdx_t b,
                                 input logic [5:0] low);
        return {op, r, b, low};
    endfunction

    task automatic put(input word_t w);
        ram[lp] = w;
        lp = lp + 16'd1;
    endtask

    task automatic loadProgram(input int t);
        logic [4:0] imm;
        word_t      d;
        for (int i = 0; i < 65536; i++) begin
            ram[i] = word_t'(i) ^ {word_t'(i) << 5} ^ 16'hA5C3;   // Address-unique fill
        end
        ram[16'h30F0] = (t == 2) ? 16'h4010 : (t == 1) ? 16'h4020 : 16'h4000;
        ram[16'h30F1] = word_t'($random(seed));
        ram[16'h30F2] = word_t'($random(seed));
        lp = 16'h3000;
        put(f9(4'h2, 3'd6, 16'h30F0));  // R6 <- output base
        case (t)
            0: begin
                imm = 5'($random(seed));
                put(f9(4'h2, 3'd1, 16'h30F1));
                put(f9(4'h2, 3'd2, 16'h30F2));
                put(f6(4'h1, 3'd3, 3'd1, 6'd2));
                put(f6(4'h7, 3'd3, 3'd6, 6'd0));
                put(f6(4'h1, 3'd3, 3'd1, {1'b1, imm}));
                put(f6(4'h7, 3'd3, 3'd6, 6'd1));
                put(f6(4'h5, 3'd3, 3'd1, 6'd2));
                put(f6(4'h7, 3'd3, 3'd6, 6'd2));
                put(f6(4'h5, 3'd3, 3'd2, {1'b1, ~imm}));
                put(f6(4'h7, 3'd3, 3'd6, 6'd3));
                put(f6(4'h9, 3'd3, 3'd1, 6'h3F));
                put(f9(4'h3, 3'd3, 16'h30E0));
            end
            1: begin
                for (int k = 0; k < 24; k++) begin
                    if (k < 8) put(f6(4'h1, 3'd5, 3'd0, 6'h21));        // Positive
                    else if (k < 16) put(f6(4'h5, 3'd5, 3'd0, 6'h20));  // Zero
                    else put(f6(4'h1, 3'd5, 3'd0, 6'h3F));              // Negative
                    put({4'h0, 3'(k), 9'd1});                           // Skips marker if taken
                    put(f6(4'h7, 3'd5, 3'd6, 6'(k - 16)));
                end
            end
            2: begin
                ram[16'h400D] = word_t'($random(seed));
                put(f9(4'h2, 3'd1, 16'h30F1));
                put(f6(4'h6, 3'd2, 3'd6, 6'h3D));   // LDR offset -3
                put(f9(4'h3, 3'd1, 16'h3080));
                put(f9(4'h3, 3'd2, 16'h2FC0));      // Negative PC offset
                put(f6(4'h7, 3'd1, 3'd6, 6'h3B));
                put(f6(4'h7, 3'd2, 3'd6, 6'd7));
                put(f6(4'h6, 3'd3, 3'd6, 6'h3B));
                put(f6(4'h7, 3'd3, 3'd6, 6'd8));
                put(f9(4'h2, 3'd4, 16'h3080));
                put(f6(4'h7, 3'd4, 3'd6, 6'd9));
            end
            3: begin
                ram[16'h30F1] = 16'h3040;
                ram[16'h30F2] = 16'h3050;
                d = 16'h3040 - (lp + 16'd1);
                put({4'h4, 1'b1, d[10:0]});     // JSR
                put(f6(4'h7, 3'd7, 3'd6, 6'd0));
                put(f9(4'h2, 3'd4, 16'h30F1));
                put(f6(4'h4, 3'd0, 3'd4, 6'd0));    // JSRR R4
                put(f6(4'h7, 3'd7, 3'd6, 6'd1));
                put(f9(4'h2, 3'd4, 16'h30F2));
                put(f6(4'hC, 3'd0, 3'd4, 6'd0));    // JMP R4
                put(f6(4'h7, 3'd0, 3'd6, 6'd9));    // Skipped path
                lp = 16'h3050;
                put(f6(4'h7, 3'd4, 3'd6, 6'd3));
                put(16'hD000);
                lp = 16'h3040;                  // Subroutine
                put(f6(4'h1, 3'd5, 3'd5, 6'h21));
                put(f6(4'h7, 3'd5, 3'd6, 6'd5));
                put(f6(4'hC, 3'd0, 3'd7, 6'd0));    // RET
            end
            4: begin
                ram[16'h0023] = 16'h3060;       // Trap vector
                put(f9(4'hE, 3'd2, 16'h30F5));
                put(f6(4'h7, 3'd2, 3'd6, 6'd0));
                put(f9(4'hE, 3'd3, 16'h2F80));
                put(f6(4'h7, 3'd3, 3'd6, 6'd1));
                put(16'hF023);
                put(f6(4'h7, 3'd7, 3'd6, 6'd2));
                put(16'hD000);
                lp = 16'h3060;
                put(f6(4'h1, 3'd5, 3'd7, 6'h23));
                put(f6(4'h7, 3'd5, 3'd6, 6'd3));
                put(f6(4'hC, 3'd0, 3'd7, 6'd0));
            end
            default: begin
                put(f6(4'h1, 3'd1, 3'd0, 6'h29));
                put(f6(4'h7, 3'd1, 3'd6, 6'd0));
                put(16'hD000);
                put(f6(4'h7, 3'd1, 3'd6, 6'd1));    // Must never run
            end
        endcase
        put(16'hD000);                          // Reserved opcode halts
    endtask

    initial begin
        string names [6];
        names   = '{"alu", "branch", "loadStore", "subroutine", "trapLea", "reservedHalt"};
        seed    = 66;
        ramData = '0;
        for (int t = 0; t < 6; t++) begin
            loadProgram(t);
            u_check.prepare();
            u_clock.applyReset();
            u_check.runTest(t, names[t]);
        end
        $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 u_check.testsRun, u_check.testsFailed, u_check.errors,
                 u_dut.u_assert.failCount);
        if (u_check.errors == 0 && u_dut.u_assert.failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
source/lc3Pkg.sv
source/lc3Control.sv
source/lc3AddrUnit.sv
source/lc3Alu.sv
source/lc3RegFile.sv
source/lc3BusUnit.sv
source/lc3Top.sv
sim/tbClock.sv
sim/lc3Tb_assert.sv
sim/lc3Checker.sv
sim/lc3Tb.sv

// File: Bender.yml
package:
  name: lc3_core

sources:
  - files:
      - source/lc3Pkg.sv
      - source/lc3Control.sv
      - source/lc3AddrUnit.sv
      - source/lc3Alu.sv
      - source/lc3RegFile.sv
      - source/lc3BusUnit.sv
      - source/lc3Top.sv
  - target: simulation
    files:
      - sim/tbClock.sv
      - sim/lc3Tb_assert.sv
      - sim/lc3Checker.sv
      - sim/lc3Tb.sv
